// File: flist.f
+incdir+src
src/cache_pkg.sv
src/icache_lookup.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_refill.sv
src/icache_top.sv
bench/tb_clock.sv
bench/mem_model.sv
bench/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_icache -o sim_icache

out=$(./obj_dir/sim_icache)
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

// File: bench/tb_icache.sv
`default_nettype none

`include "cache_defs.svh"

module tb_icache import cache_pkg::*; ();

  localparam int NUM_TESTS  = 6;
  localparam int WAIT_LIMIT = 200; // in cycles and far beyond any fill

  logic       clk;
  logic       arst_n;
  cpu_req_t   cpu_req;
  logic       cpu_ready;
  cpu_rsp_t   cpu_rsp;
  mem_req_t   mem_req;
  logic       mem_credit;
  mem_fill_t  mem_fill;
  logic [3:0] mem_delay;
  logic       hold_credits;

  int       errors;
  int       tests_passed;
  int       tests_failed;
  int       ref_misses;    // misses the model predicted so far
  int       fills = 0;     // mem_req valid cycles seen
  mem_req_t last_req = '0;
  integer   seed;

  // reference copy of the tag side
  logic [`WAYS-1:0]  ref_vld [`SETS];
  logic [`TAG_W-1:0] ref_tag [`SETS][`WAYS];
  logic              ref_lru [`SETS]; // way to evict once both are valid

  tb_clock u_clk (.clk, .arst_n);

  icache_top dut (
    .clk, .arst_n, .cpu_req, .cpu_ready, .cpu_rsp,
    .mem_req, .mem_credit, .mem_fill
  );

  mem_model u_mem (
    .clk, .arst_n, .mem_req, .mem_credit, .mem_fill,
    .delay (mem_delay), .hold_credits
  );

  always @(posedge clk) begin
    if (arst_n && mem_req.valid) begin
      fills    <= fills + 1;
      last_req <= mem_req;
    end
  end

  function automatic cache_addr_u make_addr(input int tag, input int set, input int off);
    cache_addr_u a;
    a.f.tag      = `TAG_W'(tag);
    a.f.set      = `SET_W'(set);
    a.f.off      = `OFF_W'(off);
    a.f.byte_sel = 1'b0;
    return a;
  endfunction

  function automatic logic [`WORD_W-1:0] expected_word(input cache_addr_u a);
    return {a.raw[`ADDR_W-1:1], 1'b0} ^ 16'h5A3C;
  endfunction

  // returns 1 on a predicted miss and updates state as the cache does
  function automatic logic predict_miss(input cache_addr_u a);
    logic [`SET_W-1:0] s;
    logic              w;
    s = a.f.set;
    for (int i = 0; i < `WAYS; i++) begin
      if (ref_vld[s][i] && ref_tag[s][i] == a.f.tag) begin
        ref_lru[s] = (i == 0); // other way is now lru
        return 1'b0;
      end
    end
    w = !ref_vld[s][0] ? 1'b0 : !ref_vld[s][1] ? 1'b1 : ref_lru[s];
    ref_vld[s][w] = 1'b1;
    ref_tag[s][w] = a.f.tag;
    ref_lru[s]    = ~w;
    ref_misses++;
    return 1'b1;
  endfunction

  task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t want, input string name);
    if (got !== want) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t want, input string name);
    if (got !== want) begin
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic expect_fills(input int f0, input int n, input string what);
    if (fills - f0 != n) begin
      $display("FAIL t=%0t mem_req count (%s): got %0d expected %0d",
               $time, what, fills - f0, n);
      errors++;
    end
  endtask

  // hold one request until the cache takes it and return on the cycle after
  task automatic issue_read(input cache_addr_u a);
    int n;
    n = 0;
    @(negedge clk);
    cpu_req.valid = 1'b1;
    cpu_req.addr  = a;
    while (!cpu_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_ready) begin
      $display("cache never became ready for address %h", a.raw);
      errors++;
    end
    @(negedge clk); // taken at the edge just passed
    cpu_req.valid = 1'b0;
  endtask

  // lat is 0 when the word came on the cycle right after acceptance
  task automatic wait_rsp(input cache_addr_u a, output int lat);
    cpu_rsp_t want;
    lat = 0;
    while (!cpu_rsp.valid && lat < WAIT_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    if (!cpu_rsp.valid) begin
      $display("no response for address %h", a.raw);
      errors++;
    end else begin
      want.valid = 1'b1;
      want.data  = expected_word(a);
      check_rsp(cpu_rsp, want, "cpu_rsp");
    end
  endtask

  task automatic read_check(input cache_addr_u a);
    logic     miss;
    int       f0;
    int       lat;
    mem_req_t want;
    miss = predict_miss(a);
    f0   = fills;
    issue_read(a);
    wait_rsp(a, lat);
    if (!miss) begin
      if (lat != 0) begin
        $display("hit at %h answered %0d cycles late", a.raw, lat);
        errors++;
      end
      expect_fills(f0, 0, "hit");
    end else begin
      want.valid    = 1'b1;
      want.blk_addr = {a.f.tag, a.f.set};
      expect_fills(f0, 1, "miss");
      check_req(last_req, want, "mem_req");
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    if (errors == e0) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, errors - e0);
      tests_failed++;
    end
  endtask

  task automatic cold_miss();
    int e0;
    e0        = errors;
    mem_delay = 4'd3;
    read_check(make_addr(12, 33, 5));
    finish_test("cold miss", e0);
  endtask

  // one request per cycle over the block filled by the cold miss
  task automatic block_hits();
    int          e0;
    int          f0;
    cache_addr_u a;
    cpu_rsp_t    want;
    e0 = errors;
    f0 = fills;
    a  = make_addr(12, 33, 0);
    for (int i = 0; i <= `WORDS_PER_BLK; i++) begin
      @(negedge clk);
      if (i > 0) begin
        want.valid = 1'b1;
        want.data  = expected_word(a); // a still holds word i-1
        check_rsp(cpu_rsp, want, "cpu_rsp");
      end
      if (i < `WORDS_PER_BLK) begin
        if (!cpu_ready) begin
          $display("cache stalled during back-to-back hits");
          errors++;
        end
        a.f.off = `OFF_W'(i);
        void'(predict_miss(a)); // keeps the model lru in step
        cpu_req.valid = 1'b1;
        cpu_req.addr  = a;
      end else begin
        cpu_req.valid = 1'b0;
      end
    end
    expect_fills(f0, 0, "back-to-back hits");
    finish_test("block hits", e0);
  endtask

  task automatic two_ways();
    int e0;
    int f0;
    e0 = errors;
    read_check(make_addr(3, 34, 0));
    read_check(make_addr(9, 34, 0));
    f0 = fills;
    for (int i = 0; i < 8; i++) begin
      read_check(make_addr((i % 2) ? 9 : 3, 34, i)); // ping-pong between ways
    end
    expect_fills(f0, 0, "alternating reads");
    finish_test("two ways", e0);
  endtask

  task automatic lru_replacement();
    int e0;
    int f0;
    e0 = errors;
    read_check(make_addr(4, 35, 1)); // A
    read_check(make_addr(5, 35, 2)); // B
    read_check(make_addr(4, 35, 3)); // A again so B is lru
    f0 = fills;
    read_check(make_addr(6, 35, 4)); // C evicts B
    read_check(make_addr(4, 35, 5)); // A stays
    expect_fills(f0, 1, "C replacing B");
    read_check(make_addr(5, 35, 6));
    expect_fills(f0, 2, "B after eviction");
    finish_test("lru replacement", e0);
  endtask

  task automatic credit_flow();
    int          e0;
    int          f0;
    int          lat;
    cache_addr_u a;
    mem_req_t    want;
    e0           = errors;
    mem_delay    = 4'd1;
    hold_credits = 1'b1;
    for (int i = 0; i < `REQ_CREDITS; i++) begin
      read_check(make_addr(20 + i, 36 + i, i)); // each spends one credit
    end
    f0 = fills;
    a  = make_addr(31, 45, 2);
    void'(predict_miss(a)); // fresh set and tag, so the model installs it
    issue_read(a);
    repeat (20) begin
      if (mem_req.valid || cpu_rsp.valid) begin
        $display("cache moved with no credit left at t=%0t", $time);
        errors++;
      end
      @(negedge clk);
    end
    expect_fills(f0, 0, "no credit");
    hold_credits = 1'b0; // returned slots flow back now
    wait_rsp(a, lat);
    want.valid    = 1'b1;
    want.blk_addr = {a.f.tag, a.f.set};
    expect_fills(f0, 1, "after credit return");
    check_req(last_req, want, "mem_req");
    finish_test("credit flow", e0);
  endtask

  // four tags over four sets so ways conflict often
  task automatic random_stream();
    int          e0;
    int          f0;
    int          m0;
    cache_addr_u a;
    e0 = errors;
    f0 = fills;
    m0 = ref_misses;
    for (int i = 0; i < 200; i++) begin
      a.raw        = 16'($random(seed));
      a.f.tag      = {4'd0, a.f.tag[1:0]};
      a.f.set      = {4'd0, a.f.set[1:0]};
      a.f.byte_sel = 1'b0;
      mem_delay    = 4'(i % 3);
      read_check(a);
    end
    expect_fills(f0, ref_misses - m0, "random stream");
    finish_test("random stream", e0);
  endtask

  initial begin
    cpu_req      = '0;
    mem_delay    = 4'd0;
    hold_credits = 1'b0;
    seed         = 34070;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    ref_misses   = 0;
    for (int s = 0; s < `SETS; s++) begin
      ref_vld[s] = '0;
      ref_lru[s] = 1'b0;
    end
    @(posedge arst_n);
    cold_miss();
    block_hits();
    two_ways();
    lru_replacement();
    credit_flow();
    random_stream();
    $display("tests: %0d ok, %0d failing, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // budget of 2000 time units for each test, the random stream takes the most
  initial begin
    #(NUM_TESTS * 2000);
    $display("watchdog expired, a test is stuck");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`default_nettype none

`include "cache_defs.svh"

module mem_model import cache_pkg::*; (
  input  wire logic       clk,
  input  wire logic       arst_n,
  input  wire mem_req_t   mem_req,
  output logic            mem_credit,
  output mem_fill_t       mem_fill,
  input  wire logic [3:0] delay,        // idle cycles before a burst starts
  input  wire logic       hold_credits  // keep freed slots until this drops
);

  logic [`BLK_W-1:0] reqs [$]; // accepted block requests, oldest first
  logic [`BLK_W-1:0] cur_blk;
  logic              busy;
  int                wait_n;
  int                beat_n;
  int                owed;     // slots freed but not yet handed back

  // word at byte address a is a xor 5a3c
  function automatic logic [`WORD_W-1:0] word_at(input logic [`ADDR_W-1:0] a);
    return a ^ 16'h5A3C;
  endfunction

  initial begin
    mem_credit = 1'b0;
    mem_fill   = '0;
    busy       = 1'b0;
    owed       = 0;
  end

  // all outputs move on the falling edge, the cache samples on the rising one
  always @(negedge clk) begin
    mem_credit = 1'b0;
    mem_fill   = '0;
    if (!arst_n) begin
      reqs.delete();
      busy = 1'b0;
      owed = 0;
    end else begin
      if (mem_req.valid) begin
        reqs.push_back(mem_req.blk_addr); // every request is taken
      end
      if (!busy && reqs.size() > 0) begin
        cur_blk = reqs.pop_front();
        busy    = 1'b1;
        wait_n  = int'(delay);
        beat_n  = 0;
      end else if (busy && wait_n > 0) begin
        wait_n--;
      end else if (busy) begin
        if (beat_n == 0) owed++; // slot frees as streaming starts
        mem_fill.valid = 1'b1;
        mem_fill.data  = word_at({cur_blk, 3'(beat_n), 1'b0});
        beat_n++;
        if (beat_n == `WORDS_PER_BLK) busy = 1'b0;
      end
      if (owed > 0 && !hold_credits) begin
        mem_credit = 1'b1; // one credit per cycle
        owed--;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // period 4
  end

  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // release away from the active edge
  end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`default_nettype none

`include "cache_defs.svh"

module icache_top import cache_pkg::*; (
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  wire cpu_req_t  cpu_req,
  output logic           cpu_ready,
  output cpu_rsp_t       cpu_rsp,
  output mem_req_t       mem_req,
  input  wire logic      mem_credit,
  input  wire mem_fill_t mem_fill
);

  logic [`SET_W-1:0]               rd_set;
  logic [`OFF_W-1:0]               rd_off;
  logic                            hit;
  logic                            hit_way;      // also the way touched on a hit
  logic                            victim_way;
  logic [`WAYS-1:0][`WORD_W-1:0]   way_words;
  logic                            touch;
  logic                            miss_start;
  cache_addr_u                     miss_addr;    // doubles as the stage address
  logic                            refill_done;
  logic [`WORD_W-1:0]              refill_word;
  data_wr_t                        data_wr;
  tag_upd_t                        tag_upd;

  icache_lookup u_lookup (
    .clk, .arst_n, .cpu_req, .cpu_ready, .cpu_rsp,
    .rd_set, .rd_off, .hit, .hit_way, .way_words,
    .touch, .miss_start, .miss_addr, .refill_done, .refill_word
  );

  icache_tag_array u_tags (
    .clk, .arst_n, .rd_set,
    .lookup_tag (miss_addr.f.tag), // tag of the lookup in flight
    .hit, .hit_way, .victim_way,
    .touch,
    .touch_way  (hit_way),
    .tag_upd
  );

  icache_data_array u_data (
    .clk, .rd_set, .rd_off, .way_words, .data_wr
  );

  icache_refill u_refill (
    .clk, .arst_n, .miss_start, .miss_addr, .victim_way,
    .mem_req, .mem_credit, .mem_fill,
    .data_wr, .tag_upd, .refill_done, .refill_word
  );

endmodule

`default_nettype wire

// File: src/icache_refill.sv
`default_nettype none

`include "cache_defs.svh"

module icache_refill import cache_pkg::*; (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               miss_start,
  input  wire cache_addr_u        miss_addr,
  input  wire logic               victim_way,
  output mem_req_t                mem_req,
  input  wire logic               mem_credit, // one pulse per freed slot
  input  wire mem_fill_t          mem_fill,
  output data_wr_t                data_wr,
  output tag_upd_t                tag_upd,
  output logic                    refill_done,
  output logic [`WORD_W-1:0]      refill_word
);

  localparam int                CRED_W    = $clog2(`REQ_CREDITS + 1);
  localparam logic [1:0]        S_IDLE    = 2'd0;
  localparam logic [1:0]        S_REQ     = 2'd1; // waiting for a credit
  localparam logic [1:0]        S_FILL    = 2'd2; // counting beats
  localparam logic [`OFF_W-1:0] LAST_BEAT = `OFF_W'(`WORDS_PER_BLK - 1);

  logic [1:0]         state_q;
  logic [CRED_W-1:0]  cred_q;  // request slots we may still use
  logic [`OFF_W-1:0]  beat_q;  // offset of the next fill word
  logic               done_q;  // one cycle after the last beat
  cache_addr_u        addr_q;  // missed address
  logic               way_q;   // victim, fixed for the whole fill
  logic [`WORD_W-1:0] word_q;  // the word the cpu asked for
  logic               issue;
  logic               beat;
  logic               last_beat;

  assign issue     = (state_q == S_REQ) && (cred_q != '0);
  assign beat      = (state_q == S_FILL) && mem_fill.valid;
  assign last_beat = beat && (beat_q == LAST_BEAT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_IDLE;
      cred_q  <= CRED_W'(`REQ_CREDITS);
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= last_beat;
      // spend and return may land in the same cycle
      cred_q <= cred_q - CRED_W'(issue) + CRED_W'(mem_credit);
      case (state_q)
        S_IDLE: if (miss_start) state_q <= S_REQ;
        S_REQ: begin
          if (issue) begin
            state_q <= S_FILL;
            beat_q  <= '0;
          end
        end
        S_FILL: begin
          if (beat) begin
            beat_q <= beat_q + 1'b1; // wraps to 0 after the last word
            if (last_beat) state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      addr_q <= miss_addr;
      way_q  <= victim_way; // victim is read while the set is still registered
    end
    if (beat && (beat_q == addr_q.f.off)) begin
      word_q <= mem_fill.data;
    end
  end

  assign mem_req.valid    = issue;
  assign mem_req.blk_addr = {addr_q.f.tag, addr_q.f.set};

  // each beat goes straight into the victim way, no buffering
  assign data_wr.valid = beat;
  assign data_wr.set   = addr_q.f.set;
  assign data_wr.way   = way_q;
  assign data_wr.off   = beat_q;
  assign data_wr.data  = mem_fill.data;

  // tag and valid go in only once the whole block is there
  assign tag_upd.valid = done_q;
  assign tag_upd.set   = addr_q.f.set;
  assign tag_upd.way   = way_q;
  assign tag_upd.tag   = addr_q.f.tag;

  assign refill_done = done_q;
  assign refill_word = word_q;

endmodule

`default_nettype wire

// File: src/icache_data_array.sv
`default_nettype none

`include "cache_defs.svh"

module icache_data_array import cache_pkg::*; (
  input  wire logic                    clk,
  input  wire logic [`SET_W-1:0]       rd_set,
  input  wire logic [`OFF_W-1:0]       rd_off,
  output logic [`WAYS-1:0][`WORD_W-1:0] way_words, // one word per way, next cycle
  input  wire data_wr_t                data_wr     // one fill word per cycle
);

  localparam int DEPTH = `SETS * `WORDS_PER_BLK; // words per way

  // each way is its own single-port-ish ram, indexed {set, word}
  for (genvar w = 0; w < `WAYS; w++) begin : g_way
    logic [`WORD_W-1:0]              mem [DEPTH];
    logic [`WORD_W-1:0]              rd_q;
    logic                            wr_en;
    logic [`SET_W+`OFF_W-1:0]        wr_idx;
    logic [`SET_W+`OFF_W-1:0]        rd_idx;

    assign wr_en  = data_wr.valid && (data_wr.way == 1'(w));
    assign wr_idx = {data_wr.set, data_wr.off};
    assign rd_idx = {rd_set, rd_off};

    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[wr_idx] <= data_wr.data;
      end
      rd_q <= mem[rd_idx]; // old data on a same-address write, never hit
    end

    assign way_words[w] = rd_q;
  end

endmodule

`default_nettype wire

// File: src/icache_tag_array.sv
`default_nettype none

`include "cache_defs.svh"

module icache_tag_array import cache_pkg::*; (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic [`SET_W-1:0] rd_set,     // sampled at accept
  input  wire logic [`TAG_W-1:0] lookup_tag, // tag of the stage request
  output logic                   hit,
  output logic                   hit_way,
  output logic                   victim_way,
  input  wire logic              touch,
  input  wire logic              touch_way,
  input  wire tag_upd_t          tag_upd
);

  logic [`SET_W-1:0] set_q;   // set of the lookup in flight
  logic [`SETS-1:0]  lru_q;   // 1 means way 1 is least recently used
  logic [`WAYS-1:0]  way_hit;
  logic [`WAYS-1:0]  way_vld; // valid bits of the registered set

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      set_q <= '0;
    end else begin
      set_q <= rd_set;
    end
  end

  for (genvar w = 0; w < `WAYS; w++) begin : g_way
    logic [`SETS-1:0]  vld_q;
    logic [`TAG_W-1:0] tag_mem [`SETS]; // guarded by vld_q, no reset needed
    logic              upd;

    assign upd = tag_upd.valid && (tag_upd.way == 1'(w));

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        vld_q <= '0;
      end else if (upd) begin
        vld_q[tag_upd.set] <= 1'b1; // install only, no invalidate
      end
    end

    always_ff @(posedge clk) begin
      if (upd) begin
        tag_mem[tag_upd.set] <= tag_upd.tag;
      end
    end

    // compare against the current array contents, so a line installed
    // at the accept edge is already seen by the next lookup
    assign way_vld[w] = vld_q[set_q];
    assign way_hit[w] = vld_q[set_q] && (tag_mem[set_q] == lookup_tag);
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1]; // both ways never hold the same tag

  // fill an empty way first, else evict the lru way
  assign victim_way = !way_vld[0] ? 1'b0 :
                      !way_vld[1] ? 1'b1 : lru_q[set_q];

  // the way just used becomes mru, so lru points at the other one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lru_q <= '0;
    end else if (tag_upd.valid) begin
      lru_q[tag_upd.set] <= ~tag_upd.way;
    end else if (touch) begin
      lru_q[set_q] <= ~touch_way;
    end
  end

endmodule

`default_nettype wire

// File: src/icache_lookup.sv
`default_nettype none

`include "cache_defs.svh"

module icache_lookup import cache_pkg::*; (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  input  wire cpu_req_t                      cpu_req,
  output logic                               cpu_ready,
  output cpu_rsp_t                           cpu_rsp,
  output logic [`SET_W-1:0]                  rd_set,     // to both arrays, accept cycle
  output logic [`OFF_W-1:0]                  rd_off,
  input  wire logic                          hit,        // valid the cycle after accept
  input  wire logic                          hit_way,
  input  wire logic [`WAYS-1:0][`WORD_W-1:0] way_words,
  output logic                               touch,      // lru update on hit
  output logic                               miss_start,
  output cache_addr_u                        miss_addr,
  input  wire logic                          refill_done,
  input  wire logic [`WORD_W-1:0]            refill_word
);

  logic        run_q;       // goes high on first edge out of reset
  logic        blocked_q;   // miss handed off, waiting for refill
  logic        stg_valid_q; // one lookup in flight
  cache_addr_u stg_addr_q;  // address of that lookup
  logic        miss;
  logic        accept;

  // a lookup that found neither way
  assign miss = stg_valid_q & ~hit;

  // refill_done reopens the port in the same cycle the missed word goes out
  assign cpu_ready = run_q & ~miss & (~blocked_q | refill_done);
  assign accept    = cpu_req.valid & cpu_ready;

  // arrays read straight off the request so data lands next cycle
  assign rd_set = cpu_req.addr.f.set;
  assign rd_off = cpu_req.addr.f.off;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q       <= 1'b0;
      blocked_q   <= 1'b0;
      stg_valid_q <= 1'b0;
    end else begin
      run_q       <= 1'b1;
      stg_valid_q <= accept; // ready is low on a miss, so this clears it
      if (miss) begin
        blocked_q <= 1'b1;
      end else if (refill_done) begin
        blocked_q <= 1'b0;
      end
    end
  end

  // stage address only matters while stg_valid_q is set
  always_ff @(posedge clk) begin
    if (accept) begin
      stg_addr_q <= cpu_req.addr;
    end
  end

  assign touch      = stg_valid_q & hit;
  assign miss_start = miss; // single pulse, stage empties next edge
  assign miss_addr  = stg_addr_q;

  // hit and refill never share a cycle, stage is empty during refill_done
  assign cpu_rsp.valid = touch | refill_done;
  assign cpu_rsp.data  = refill_done ? refill_word : way_words[hit_way];

endmodule

`default_nettype wire

// File: src/cache_pkg.sv
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

  // field view of a byte address
  typedef struct packed {
    logic [`TAG_W-1:0] tag;
    logic [`SET_W-1:0] set;
    logic [`OFF_W-1:0] off;      // word within block
    logic              byte_sel; // ignored, word access only
  } addr_fields_t;

  // same 16 bits seen as a raw address or as its fields
  typedef union packed {
    logic [`ADDR_W-1:0] raw;
    addr_fields_t       f;
  } cache_addr_u;

  typedef struct packed {
    logic        valid;
    cache_addr_u addr;
  } cpu_req_t;

  typedef struct packed {
    logic              valid;
    logic [`WORD_W-1:0] data;
  } cpu_rsp_t;

  typedef struct packed {
    logic              valid;
    logic [`BLK_W-1:0] blk_addr; // {tag, set}
  } mem_req_t;

  // one beat of a fill burst, words 0..7 in order
  typedef struct packed {
    logic              valid;
    logic [`WORD_W-1:0] data;
  } mem_fill_t;

  typedef struct packed {
    logic              valid;
    logic [`SET_W-1:0] set;
    logic              way;
    logic [`TAG_W-1:0] tag;
  } tag_upd_t;

  typedef struct packed {
    logic               valid;
    logic [`SET_W-1:0]  set;
    logic               way;
    logic [`OFF_W-1:0]  off;
    logic [`WORD_W-1:0] data;
  } data_wr_t;

endpackage

`default_nettype wire

// File: src/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address and data widths of the 16-bit core
`define ADDR_W 16
`define WORD_W 16

// cache geometry, 2 KB total
`define SETS          64
`define WAYS          2
`define WORDS_PER_BLK 8 // also the fill burst length

// field widths inside an address
`define TAG_W 6
`define SET_W 6
`define OFF_W 3 // word offset within a block

// block address sent to memory is tag plus set
`define BLK_W (`TAG_W + `SET_W)

// request slots memory hands us out of reset, 1, 2 or 4 all work
`define REQ_CREDITS 2

`endif // CACHE_DEFS_SVH
